/* src/nocPkg.sv */
package nocPkg;

  // fixed by the flit format.
  localparam int numPorts = 5;
  localparam int flitWidth = 32;
  localparam int idWidth = 3;
  localparam int lengthWidth = 12;
  localparam int destWidth = 4;
  localparam int reservedWidth = flitWidth - idWidth - lengthWidth - destWidth;
  localparam int payloadWidth = flitWidth - idWidth;

  // flit id codes.
  localparam logic [idWidth-1:0] headId = 3'b001;
  localparam logic [idWidth-1:0] bodyId = 3'b010;
  localparam logic [idWidth-1:0] tailId = 3'b011;

  // one-hot grant codes, also the arbiter states.
  localparam logic [numPorts:0] grantIdle = 6'b000001;
  localparam logic [numPorts:0] grantL    = 6'b000010;
  localparam logic [numPorts:0] grantN    = 6'b000100;
  localparam logic [numPorts:0] grantE    = 6'b001000;
  localparam logic [numPorts:0] grantW    = 6'b010000;
  localparam logic [numPorts:0] grantS    = 6'b100000;

  typedef struct packed
  {
    logic [idWidth-1:0]       flitId;
    logic [lengthWidth-1:0]   length;   // grant budget.
    logic [destWidth-1:0]     dest;
    logic [reservedWidth-1:0] reserved;
  } flitHead_t;

  typedef struct packed
  {
    logic [idWidth-1:0]      flitId;
    logic [payloadWidth-1:0] payload;
  } flitBody_t;

  // id sits in the same bits in both views.
  typedef union packed
  {
    flitHead_t head;
    flitBody_t body;
  } flitWord_t;

  typedef struct packed
  {
    logic      req;
    flitWord_t flit;
  } portReq_t;

endpackage

/* src/grantTimer.sv */
`timescale 1ns/100ps

module grantTimer
(
  input  logic              clk,
  input  logic              rst,
  input  nocPkg::flitWord_t flit,
  input  logic              run,
  output logic              timesUp
);

  import nocPkg::*;

  logic [lengthWidth-1:0] limit;
  logic [lengthWidth-1:0] count;

  // budget follows any head on the port, granted or not.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
    end
    else if (flit.head.flitId == headId)
    begin
      limit <= flit.head.length;
    end
  end

  // counts held-grant cycles.
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (run)
    begin
      count <= count + 1'b1;
    end
    else
    begin
      count <= '0;  // back to zero once released.
    end
  end

  assign timesUp = (count == limit);

endmodule

/* src/portArbiter.sv */
`timescale 1ns/100ps

module portArbiter
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  nocPkg::portReq_t [nocPkg::numPorts-1:0] portIn,
  output logic [nocPkg::numPorts:0]               grant
);

  import nocPkg::*;

  logic [numPorts:0]   state;
  logic [numPorts:0]   nextState;
  logic [numPorts-1:0] reqs;
  logic [numPorts-1:0] run;
  logic [numPorts-1:0] timesUp;

  // port order is L, N, E, W, S.
  genvar p;
  generate
    for (p = 0; p < numPorts; p++)
    begin : g_port
      assign reqs[p] = portIn[p].req;

      grantTimer i_timer
      (
        .clk     (clk),
        .rst     (rst),
        .flit    (portIn[p].flit),
        .run     (run[p]),
        .timesUp (timesUp[p])
      );
    end
  endgenerate

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state <= grantIdle;
    end
    else
    begin
      state <= nextState;
    end
  end

  // owner is skipped when its grant ends, so a lone requester idles a cycle.
  always_comb
  begin
    run = '0;
    nextState = grantIdle;
    case (state)
      grantIdle:
      begin
        if (reqs[0])
          nextState = grantL;
        else if (reqs[1])
          nextState = grantN;
        else if (reqs[2])
          nextState = grantE;
        else if (reqs[3])
          nextState = grantW;
        else if (reqs[4])
          nextState = grantS;
      end
      grantL:
      begin
        if (reqs[0] && !timesUp[0])
        begin
          run[0] = 1'b1;
          nextState = grantL;
        end
        else if (reqs[1])
          nextState = grantN;
        else if (reqs[2])
          nextState = grantE;
        else if (reqs[3])
          nextState = grantW;
        else if (reqs[4])
          nextState = grantS;
      end
      grantN:
      begin
        if (reqs[1] && !timesUp[1])
        begin
          run[1] = 1'b1;
          nextState = grantN;
        end
        else if (reqs[2])
          nextState = grantE;
        else if (reqs[3])
          nextState = grantW;
        else if (reqs[4])
          nextState = grantS;
        else if (reqs[0])
          nextState = grantL;
      end
      grantE:
      begin
        if (reqs[2] && !timesUp[2])
        begin
          run[2] = 1'b1;
          nextState = grantE;
        end
        else if (reqs[3])
          nextState = grantW;
        else if (reqs[4])
          nextState = grantS;
        else if (reqs[0])
          nextState = grantL;
        else if (reqs[1])
          nextState = grantN;
      end
      grantW:
      begin
        if (reqs[3] && !timesUp[3])
        begin
          run[3] = 1'b1;
          nextState = grantW;
        end
        else if (reqs[4])
          nextState = grantS;
        else if (reqs[0])
          nextState = grantL;
        else if (reqs[1])
          nextState = grantN;
        else if (reqs[2])
          nextState = grantE;
      end
      grantS:
      begin
        if (reqs[4] && !timesUp[4])
        begin
          run[4] = 1'b1;
          nextState = grantS;
        end
        else if (reqs[0])
          nextState = grantL;
        else if (reqs[1])
          nextState = grantN;
        else if (reqs[2])
          nextState = grantE;
        else if (reqs[3])
          nextState = grantW;
      end
      default:
      begin
        nextState = grantIdle;  // illegal code recovers to idle.
      end
    endcase
  end

  assign grant = state;

endmodule

/* src/outputStage.sv */
`timescale 1ns/100ps

module outputStage
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  nocPkg::portReq_t [nocPkg::numPorts-1:0] portIn,
  input  logic [nocPkg::numPorts:0]               grant,
  output logic                                   outValid,
  output nocPkg::flitWord_t                      outFlit
);

  import nocPkg::*;

  logic                 selReq;
  logic [flitWidth-1:0] selFlit;

  // and-or mux on the port bits, idle bit selects nothing.
  always_comb
  begin
    selReq = 1'b0;
    selFlit = '0;
    for (int i = 0; i < numPorts; i++)
    begin
      selReq = selReq | (portIn[i].req & grant[i+1]);
      selFlit = selFlit | (portIn[i].flit & {flitWidth{grant[i+1]}});
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      outValid <= 1'b0;
      outFlit <= '0;
    end
    else
    begin
      outValid <= selReq;
      outFlit <= selFlit;  // one cycle behind portIn.
    end
  end

endmodule

/* src/routerOutputPort.sv */
`timescale 1ns/100ps

module routerOutputPort
(
  input  logic                                   clk,
  input  logic                                   rst,
  input  nocPkg::portReq_t [nocPkg::numPorts-1:0] portIn,
  output logic [nocPkg::numPorts:0]               grant,
  output logic                                   outValid,
  output nocPkg::flitWord_t                      outFlit
);

  // grant is also exported, it names the input the link serves.
  portArbiter i_arbiter
  (
    .clk    (clk),
    .rst    (rst),
    .portIn (portIn),
    .grant  (grant)
  );

  outputStage i_outputStage
  (
    .clk      (clk),
    .rst      (rst),
    .portIn   (portIn),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

endmodule

/* bench/tbRouterOutputPort.sv */
`timescale 1ns/100ps

module tbRouterOutputPort;

  import nocPkg::*;

  localparam int maxCycles = 130;  // about twice the length of all tests.

  logic                          clk;
  logic                          rst;
  portReq_t [numPorts-1:0]       portIn;
  logic [numPorts:0]             grant;
  logic                          outValid;
  flitWord_t                     outFlit;

  int errorCount;
  int checkCount;
  int cycleCount;

  // datapath monitor state.
  logic      checkData;
  logic      havePrev;
  logic      expValid;
  flitWord_t expFlit;

  routerOutputPort i_dut
  (
    .clk      (clk),
    .rst      (rst),
    .portIn   (portIn),
    .grant    (grant),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  always #50 clk = ~clk;

  task automatic compareValue(input string what, input logic [63:0] got,
                              input logic [63:0] want);
    begin
      checkCount++;
      if (got !== want)
      begin
        errorCount++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, what, got, want);
      end
    end
  endtask

  // port index named by a one-hot grant, -1 for idle.
  function automatic int portOfGrant(input logic [numPorts:0] g);
    case (g)
      grantL: return 0;
      grantN: return 1;
      grantE: return 2;
      grantW: return 3;
      grantS: return 4;
      default: return -1;
    endcase
  endfunction

  task automatic sendHead(input int port, input int length);
    portReq_t r;
    begin
      r = '0;
      r.req = 1'b1;
      r.flit.head.flitId = headId;
      r.flit.head.length = 12'(length);
      r.flit.head.dest = 4'($urandom());
      portIn[port] <= r;
    end
  endtask

  task automatic sendBody(input int port);
    portReq_t r;
    begin
      r.req = 1'b1;
      r.flit.body.flitId = bodyId;
      r.flit.body.payload = 29'($urandom());  // random payload.
      portIn[port] <= r;
    end
  endtask

  task automatic releasePort(input int port);
    portIn[port] <= '0;
  endtask

  task automatic waitCycles(input int n);
    repeat (n) @(posedge clk);
  endtask

  // bounded wait for the link to fall back to idle.
  task automatic waitForIdle(input int limit);
    int n;
    begin
      n = 0;
      @(negedge clk);
      while (grant !== grantIdle && n < limit)
      begin
        @(negedge clk);
        n++;
      end
      if (grant !== grantIdle)
      begin
        errorCount++;
        $display("grant did not return to idle within %0d cycles", limit);
      end
    end
  endtask

  task automatic resetState;
    begin
      for (int i = 0; i < 10; i++)
      begin
        @(posedge clk);
        if (i == 9)
          rst <= 1'b0;  // tenth edge is the last in reset.
        @(negedge clk);
        compareValue("grant in reset", grant, grantIdle);
        compareValue("outValid in reset", outValid, 1'b0);
      end
      @(negedge clk);
      compareValue("grant after reset", grant, grantIdle);
      compareValue("outValid after reset", outValid, 1'b0);
    end
  endtask

  // N alone with length 4 holds for 5 cycles, idles one, then regains.
  task automatic budgetTimeout;
    begin
      @(posedge clk);
      sendHead(1, 4);
      @(negedge clk);
      compareValue("grant before first edge", grant, grantIdle);
      for (int i = 0; i < 7; i++)
      begin
        @(posedge clk);
        sendBody(1);
        @(negedge clk);
        compareValue("budget timeout grant", grant, (i == 5) ? grantIdle : grantN);
      end
      @(posedge clk);
      releasePort(1);
      waitForIdle(4);
    end
  endtask

  task automatic idlePriority;
    begin
      @(posedge clk);
      for (int p = 0; p < numPorts; p++)
        sendHead(p, 2);
      @(negedge clk);
      compareValue("grant before requests seen", grant, grantIdle);
      @(posedge clk);
      portIn <= '0;
      @(negedge clk);
      compareValue("idle priority grant", grant, grantL);
      waitForIdle(4);
    end
  endtask

  task automatic roundRobin;
    logic [numPorts:0] order [6];
    begin
      order = '{grantL, grantN, grantE, grantW, grantS, grantL};
      @(posedge clk);
      for (int p = 0; p < numPorts; p++)
        sendHead(p, 2);
      for (int i = 0; i < 18; i++)
      begin
        @(posedge clk);
        for (int p = 0; p < numPorts; p++)
          sendBody(p);
        @(negedge clk);
        compareValue("round robin grant", grant, order[i / 3]);  // 3 cycles each.
      end
      @(posedge clk);
      portIn <= '0;
      waitForIdle(4);
    end
  endtask

  // W owns the link, L and E wait, S is silent.
  task automatic earlyRelease;
    begin
      @(posedge clk);
      sendHead(3, 10);
      @(negedge clk);
      compareValue("grant before W seen", grant, grantIdle);
      @(posedge clk);
      sendBody(3);
      sendHead(0, 2);
      sendHead(2, 2);
      @(negedge clk);
      compareValue("W granted", grant, grantW);
      @(posedge clk);
      sendBody(3);
      sendBody(0);
      sendBody(2);
      @(negedge clk);
      compareValue("W holds", grant, grantW);
      @(posedge clk);
      releasePort(3);
      sendBody(0);
      sendBody(2);
      @(negedge clk);
      compareValue("W still granted on release edge", grant, grantW);
      @(posedge clk);
      sendBody(0);
      sendBody(2);
      @(negedge clk);
      compareValue("grant after W release", grant, grantL);
      @(posedge clk);
      portIn <= '0;
      waitForIdle(4);
    end
  endtask

  // output one cycle behind the granted input.
  always @(negedge clk)
  begin
    int port;
    if (checkData && havePrev)
    begin
      compareValue("outValid", outValid, expValid);
      compareValue("outFlit", outFlit, expFlit);
    end
    port = portOfGrant(grant);
    expValid = 1'b0;
    expFlit = '0;
    if (port >= 0)
    begin
      expValid = portIn[port].req;
      expFlit = portIn[port].flit;
    end
    havePrev = checkData;
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount > maxCycles)
    begin
      $display("run timed out after %0d cycles", maxCycles);
      $display("checks: %0d  errors: %0d  timeout", checkCount, errorCount);
      $display("Finished with errors");
      $finish;
    end
  end

  initial
  begin
    void'($urandom(32'hd655));
    clk = 1'b0;
    errorCount = 0;
    checkCount = 0;
    cycleCount = 0;
    checkData = 1'b0;
    havePrev = 1'b0;
    rst <= 1'b1;
    portIn <= '0;

    resetState();
    @(posedge clk);
    checkData = 1'b1;
    budgetTimeout();
    waitCycles(2);
    idlePriority();
    waitCycles(2);
    roundRobin();
    waitCycles(2);
    earlyRelease();
    waitCycles(2);
    checkData = 1'b0;

    $display("checks: %0d  errors: %0d", checkCount, errorCount);
    if (errorCount == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

/* flist.f */
src/nocPkg.sv
src/grantTimer.sv
src/portArbiter.sv
src/outputStage.sv
src/routerOutputPort.sv
bench/tbRouterOutputPort.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tbRouterOutputPort -f flist.f -o simv
	./obj_dir/simv | tee sim.log
	grep -q "Finished with no errors" sim.log

clean:
	rm -rf obj_dir sim.log
